/* tbInput.txt */
// Columns: test, op, address, write data or wait cycles, expected read value (hex)
// Ops: 1 write, 2 read and compare, 3 wait cycles, 4 check interrupt, F end
// Test 1: reset values of IIR, LSR and the interrupt
1 2 40000008 0 1
1 2 40000014 0 60
1 4 0 0 0
// Test 2: divisor latch and IER read back
2 1 4000000C 80 0
2 1 40000000 A5 0
2 1 40000004 3C 0
2 2 40000000 0 A5
2 2 40000004 0 3C
2 2 4000000C 0 80
2 1 4000000C 0 0
2 1 40000004 2 0
2 2 40000004 0 2
2 2 40000008 0 2
2 4 0 0 1
2 1 40000004 0 0
2 4 0 0 0
// Test 3: write and read handshakes
3 1 4000000C 0 0
3 2 4000000C 0 0
3 2 40000004 0 0
// Test 4: one byte looped back with divisor 2
4 1 4000000C 80 0
4 1 40000000 2 0
4 1 40000004 0 0
4 1 4000000C 0 0
4 1 40000000 5A 0
4 2 40000014 0 20
4 3 0 190 0
4 2 40000014 0 61
4 2 40000000 0 5A
4 2 40000014 0 60
// Test 5: three bytes back to back, more than the credits
5 1 40000000 11 0
5 1 40000000 22 0
5 1 40000000 33 0
5 3 0 44C 0
5 2 40000014 0 61
5 2 40000000 0 11
5 2 40000000 0 22
5 2 40000000 0 33
5 2 40000014 0 60
// Test 6: data ready interrupt and receive overrun
6 1 40000004 1 0
6 4 0 0 0
6 2 40000008 0 1
6 1 40000000 A7 0
6 3 0 190 0
6 4 0 0 1
6 2 40000008 0 4
6 2 40000000 0 A7
6 4 0 0 0
6 1 40000000 1 0
6 1 40000000 2 0
6 1 40000000 3 0
6 1 40000000 4 0
6 1 40000000 5 0
6 3 0 708 0
6 2 40000014 0 63
6 2 40000014 0 61
6 2 40000000 0 1
6 2 40000000 0 2
6 2 40000000 0 3
6 2 40000000 0 4
6 2 40000014 0 60
6 4 0 0 0
0 F 0 0 0

/* sim.f */
uartPkg.sv
ahbUartDecode.sv
uartRegs.sv
uartTx.sv
uartRx.sv
ahbUart.sv
tbAhbUart.sv

/* Makefile */
# Verilator build and run for the AHB UART testbench

VERILATOR ?= verilator
TOP       ?= tbAhbUart
FILELIST  ?= sim.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary -j 0
PASS_TEXT ?= Testbench passed

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  help   list the targets"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove the build directory"
	@echo "Variables: VERILATOR TOP FILELIST BUILD_DIR VFLAGS"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)
	@out="$$(./$(BUILD_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "$(PASS_TEXT)"

clean:
	rm -rf $(BUILD_DIR)

/* tbAhbUart.sv */
// ============================
// AHB UART testbench
// ============================

`timescale 1ns/1ps
`default_nettype none

module tbAhbUart;

    localparam int CLK_HALF      = 10;
    localparam int DRIVE_DELAY   = 2;
    localparam int RESET_CYCLES  = 16;
    localparam int MAX_ENTRIES   = 64;
    localparam int FIELDS        = 5;       // Test, op, address, data, expected
    localparam int MARGIN_CYCLES = 4000;
    localparam int MAX_WAIT      = 8;       // Bound on HREADY low per transfer

    localparam logic [31:0] OP_WRITE = 32'h1;
    localparam logic [31:0] OP_READ  = 32'h2;
    localparam logic [31:0] OP_WAIT  = 32'h3;
    localparam logic [31:0] OP_INT   = 32'h4;
    localparam logic [31:0] OP_END   = 32'hF;

    logic        HCLK;
    logic        HRESETn;
    logic        hSel;
    logic [1:0]  hTrans;
    logic        hWrite;
    logic [31:0] hAddr;
    logic [31:0] hWData;
    logic [31:0] hRData;
    logic        hReady;
    logic        hResp;
    logic        uartInt;
    wire         uartLine;                  // TX looped back to RX

    logic [31:0] stim [FIELDS*MAX_ENTRIES];
    int          cycleCount  = 0;
    int          cycleLimit  = 0;
    int          testErrors  = 0;
    int          errorCount  = 0;
    int          testsPassed = 0;
    int          testsFailed = 0;

    ahbUart ahbUart_i (
        .HCLK      (HCLK),
        .HRESETn   (HRESETn),
        .hSel_i    (hSel),
        .hTrans_i  (hTrans),
        .hWrite_i  (hWrite),
        .hAddr_i   (hAddr),
        .hWData_i  (hWData),
        .hRData_o  (hRData),
        .hReady_o  (hReady),
        .hResp_o   (hResp),
        .uartRx_i  (uartLine),
        .uartTx_o  (uartLine),
        .uartInt_o (uartInt)
    );

    always #(CLK_HALF) HCLK = ~HCLK;

    always @(posedge HCLK) begin
        cycleCount <= cycleCount + 1;
    end

    initial begin : watchdog
        wait (cycleLimit != 0);
        wait (cycleCount >= cycleLimit);
        $display("Timeout: run did not end within %0d cycles", cycleLimit);
        $display("Testbench failed");
        $finish;
    end

    task automatic reportMismatch(input string name, input logic [31:0] got,
                                  input logic [31:0] expected);
        $display("FAIL at %0d ns: %s is %h, expected %h", $time, name, got, expected);
        testErrors++;
    endtask

    task automatic finishTest(input string label);
        if (testErrors == 0) begin
            $display("%s: passed", label);
            testsPassed++;
        end else begin
            $display("%s: failed with %0d errors", label, testErrors);
            testsFailed++;
        end
        errorCount += testErrors;
        testErrors = 0;
    endtask

    task automatic busWrite(input logic [31:0] addr, input logic [31:0] data);
        int lowCycles;
        lowCycles = 0;
        @(posedge HCLK);
        #DRIVE_DELAY;
        hSel   = 1'b1;                      // Address phase
        hTrans = 2'b10;
        hWrite = 1'b1;
        hAddr  = addr;
        @(negedge HCLK);
        if (hReady !== 1'b1) begin
            reportMismatch("hReady_o in write address phase", 32'(hReady), 32'h1);
        end
        @(posedge HCLK);
        #DRIVE_DELAY;
        hSel   = 1'b0;                      // Data phase
        hTrans = 2'b00;
        hWrite = 1'b0;
        hWData = data;
        @(negedge HCLK);
        while (hReady !== 1'b1 && lowCycles < MAX_WAIT) begin
            lowCycles++;
            @(negedge HCLK);
        end
        if (hReady !== 1'b1) begin
            $display("Write to %h never completed, HREADY stayed low", addr);
            testErrors++;
        end else if (lowCycles != 1) begin
            reportMismatch("hReady_o wait states on write", 32'(lowCycles), 32'h1);
        end
        if (hResp !== 1'b0) begin
            reportMismatch("hResp_o", 32'(hResp), 32'h0);
        end
    endtask

    task automatic busRead(input logic [31:0] addr, output logic [31:0] data);
        @(posedge HCLK);
        #DRIVE_DELAY;
        hSel   = 1'b1;
        hTrans = 2'b10;
        hWrite = 1'b0;
        hAddr  = addr;
        @(negedge HCLK);
        if (hReady !== 1'b1) begin
            reportMismatch("hReady_o in read address phase", 32'(hReady), 32'h1);
        end
        @(posedge HCLK);
        #DRIVE_DELAY;
        hSel   = 1'b0;
        hTrans = 2'b00;
        @(negedge HCLK);
        if (hReady !== 1'b1) begin
            reportMismatch("hReady_o in read data phase", 32'(hReady), 32'h1);
        end
        if (hResp !== 1'b0) begin
            reportMismatch("hResp_o", 32'(hResp), 32'h0);
        end
        data = hRData;                      // Zero wait states
    endtask

    task automatic checkInterrupt(input logic [31:0] expected);
        @(negedge HCLK);
        if (uartInt !== expected[0]) begin
            reportMismatch("uartInt_o", 32'(uartInt), expected);
        end
    endtask

    initial begin : mainFlow
        int          idx;
        int          lowCycles;
        int          waitSum;
        logic [31:0] curTest;
        logic [31:0] entryTest;
        logic [31:0] entryOp;
        logic [31:0] entryAddr;
        logic [31:0] entryData;
        logic [31:0] entryExp;
        logic [31:0] rdata;

        HCLK    = 1'b0;
        HRESETn = 1'b0;
        hSel    = 1'b0;
        hTrans  = 2'b00;
        hWrite  = 1'b0;
        hAddr   = 32'h0;
        hWData  = 32'h0;

        $readmemh("tbInput.txt", stim);
        if (stim[1] === 32'hx) begin
            $display("Stimulus file tbInput.txt could not be read");
            errorCount++;
        end

        // Run limit from the total of all wait operations
        waitSum = 0;
        for (idx = 0; idx < MAX_ENTRIES; idx++) begin
            if (stim[idx*FIELDS+1] === OP_WAIT) begin
                waitSum += int'(stim[idx*FIELDS+3]);
            end
        end
        cycleLimit = waitSum + MARGIN_CYCLES;

        repeat (RESET_CYCLES) @(posedge HCLK);
        #DRIVE_DELAY;
        HRESETn = 1'b1;

        // Slave ready after one INIT cycle
        lowCycles = 0;
        @(negedge HCLK);
        while (hReady !== 1'b1 && lowCycles < MAX_WAIT) begin
            lowCycles++;
            @(negedge HCLK);
        end
        if (lowCycles != 1) begin
            reportMismatch("hReady_o cycles low after reset", 32'(lowCycles), 32'h1);
        end
        if (uartLine !== 1'b1) begin
            reportMismatch("uartTx_o after reset", 32'(uartLine), 32'h1);
        end
        if (uartInt !== 1'b0) begin
            reportMismatch("uartInt_o after reset", 32'(uartInt), 32'h0);
        end
        finishTest("reset");

        idx     = 0;
        curTest = stim[0];
        while (idx < MAX_ENTRIES && stim[idx*FIELDS+1] !== OP_END) begin
            entryTest = stim[idx*FIELDS];
            entryOp   = stim[idx*FIELDS+1];
            entryAddr = stim[idx*FIELDS+2];
            entryData = stim[idx*FIELDS+3];
            entryExp  = stim[idx*FIELDS+4];
            if (entryTest !== curTest) begin
                finishTest($sformatf("test %0d", curTest));
                curTest = entryTest;
            end
            case (entryOp)
                OP_WRITE: busWrite(entryAddr, entryData);
                OP_READ: begin
                    busRead(entryAddr, rdata);
                    if (rdata !== entryExp) begin
                        reportMismatch($sformatf("hRData_o from %h", entryAddr), rdata, entryExp);
                    end
                end
                OP_WAIT:  repeat (entryData) @(posedge HCLK);
                OP_INT:   checkInterrupt(entryExp);
                default: begin
                    $display("Unknown operation %h in stimulus entry %0d", entryOp, idx);
                    testErrors++;
                end
            endcase
            idx++;
        end
        finishTest($sformatf("test %0d", curTest));

        $display("Tests passed: %0d, tests failed: %0d, errors: %0d",
                 testsPassed, testsFailed, errorCount);
        if (testsFailed == 0 && errorCount == 0) begin
            $display("Testbench passed");
        end else begin
            $display("Testbench failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* ahbUart.sv */
// ============================
// AHB-Lite UART top
// ============================

`timescale 1ns/1ps
`default_nettype none

module ahbUart
    import uartPkg::*;
(
    input  wire         HCLK,
    input  wire         HRESETn,
    input  wire         hSel_i,
    input  wire [1:0]   hTrans_i,
    input  wire         hWrite_i,
    input  wire [31:0]  hAddr_i,
    input  wire [31:0]  hWData_i,
    output logic [31:0] hRData_o,
    output logic        hReady_o,
    output logic        hResp_o,
    input  wire         uartRx_i,
    output logic        uartTx_o,
    output logic        uartInt_o
);

    regAddrT regAddr;
    byteT    regWData;
    byteT    regRData;
    logic    regWrite;
    logic    regRead;
    logic    baudTick;
    logic    txValid;
    byteT    txData;
    logic    txCredit;
    logic    txBusy;
    logic    rxValid;
    byteT    rxData;

    ahbUartDecode decode_i (
        .HCLK       (HCLK),
        .HRESETn    (HRESETn),
        .hSel_i     (hSel_i),
        .hTrans_i   (hTrans_i),
        .hWrite_i   (hWrite_i),
        .hAddr_i    (hAddr_i),
        .hWData_i   (hWData_i),
        .hRData_o   (hRData_o),
        .hReady_o   (hReady_o),
        .hResp_o    (hResp_o),
        .regAddr_o  (regAddr),
        .regWData_o (regWData),
        .regWrite_o (regWrite),
        .regRead_o  (regRead),
        .regRData_i (regRData)
    );

    uartRegs regs_i (
        .HCLK       (HCLK),
        .HRESETn    (HRESETn),
        .regAddr_i  (regAddr),
        .regWData_i (regWData),
        .regWrite_i (regWrite),
        .regRead_i  (regRead),
        .regRData_o (regRData),
        .baudTick_o (baudTick),
        .txValid_o  (txValid),
        .txData_o   (txData),
        .txCredit_i (txCredit),
        .txBusy_i   (txBusy),
        .rxValid_i  (rxValid),
        .rxData_i   (rxData),
        .uartInt_o  (uartInt_o)
    );

    uartTx tx_i (
        .HCLK       (HCLK),
        .HRESETn    (HRESETn),
        .baudTick_i (baudTick),
        .txValid_i  (txValid),
        .txData_i   (txData),
        .txCredit_o (txCredit),
        .txBusy_o   (txBusy),
        .uartTx_o   (uartTx_o)
    );

    uartRx rx_i (
        .HCLK       (HCLK),
        .HRESETn    (HRESETn),
        .baudTick_i (baudTick),
        .uartRx_i   (uartRx_i),
        .rxValid_o  (rxValid),
        .rxData_o   (rxData)
    );

endmodule

`default_nettype wire

/* uartRx.sv */
// ============================
// UART 8N1 receiver
// ============================

`timescale 1ns/1ps
`default_nettype none

module uartRx
    import uartPkg::*;
(
    input  wire   HCLK,
    input  wire   HRESETn,
    input  wire   baudTick_i,
    input  wire   uartRx_i,
    output logic  rxValid_o,
    output byteT  rxData_o
);

    logic [1:0] rxSync;           // Two-flop synchronizer
    logic       rxIn;
    rxStateT    state;
    byteT       shiftReg;
    logic [3:0] tickCnt;
    logic [2:0] bitCnt;
    logic       halfBit;
    logic       fullBit;

    assign rxIn    = rxSync[1];
    assign halfBit = baudTick_i && (tickCnt == 4'd7);
    assign fullBit = baudTick_i && (tickCnt == 4'd15);

    always_ff @(posedge HCLK) begin
        if (!HRESETn) begin
            rxSync <= 2'b11;            // Idle line is high
        end else begin
            rxSync <= {rxSync[0], uartRx_i};
        end
    end

    always_ff @(posedge HCLK) begin
        if (!HRESETn) begin
            state     <= RX_IDLE;
            tickCnt   <= '0;
            bitCnt    <= '0;
            rxValid_o <= 1'b0;
        end else begin
            rxValid_o <= 1'b0;
            if (state != RX_IDLE && baudTick_i) begin
                tickCnt <= tickCnt + 1'b1;
            end
            case (state)
                RX_IDLE: begin
                    if (!rxIn) begin
                        state   <= RX_START;
                        tickCnt <= '0;
                    end
                end
                RX_START: begin
                    // Still low at mid start bit, otherwise a glitch
                    if (halfBit) begin
                        state   <= rxIn ? RX_IDLE : RX_DATA;
                        tickCnt <= '0;
                        bitCnt  <= '0;
                    end
                end
                RX_DATA: begin
                    if (fullBit) begin
                        bitCnt <= bitCnt + 1'b1;
                        if (bitCnt == 3'd7) begin
                            state <= RX_STOP;
                        end
                    end
                end
                RX_STOP: begin
                    if (fullBit) begin
                        state     <= RX_IDLE;
                        rxValid_o <= rxIn;      // Low stop bit is a framing error
                    end
                end
                default: state <= RX_IDLE;
            endcase
        end
    end

    always_ff @(posedge HCLK) begin
        if (state == RX_DATA && fullBit) begin
            shiftReg <= {rxIn, shiftReg[7:1]};
        end
    end

    assign rxData_o = shiftReg;

endmodule

`default_nettype wire

/* uartTx.sv */
// ============================
// UART 8N1 transmitter
// ============================

`timescale 1ns/1ps
`default_nettype none

module uartTx
    import uartPkg::*;
(
    input  wire   HCLK,
    input  wire   HRESETn,
    input  wire   baudTick_i,
    input  wire   txValid_i,
    input  byteT  txData_i,
    output logic  txCredit_o,
    output logic  txBusy_o,
    output logic  uartTx_o
);

    byteT                          holdBuf [TX_CREDITS];
    logic [$clog2(TX_CREDITS)-1:0] bufWrPtr;
    logic [$clog2(TX_CREDITS)-1:0] bufRdPtr;
    creditT                        bufCount;

    txStateT    state;
    byteT       shiftReg;
    logic [3:0] tickCnt;          // 16 ticks per bit
    logic [2:0] bitCnt;
    logic       load;
    logic       bitDone;

    assign load    = (state == TX_IDLE) && (bufCount != '0);
    assign bitDone = baudTick_i && (tickCnt == 4'd15);

    always_ff @(posedge HCLK) begin
        if (!HRESETn) begin
            bufWrPtr <= '0;
            bufRdPtr <= '0;
            bufCount <= '0;
        end else begin
            if (txValid_i) begin
                bufWrPtr <= bufWrPtr + 1'b1;
            end
            if (load) begin
                bufRdPtr <= bufRdPtr + 1'b1;
            end
            case ({txValid_i, load})
                2'b10:   bufCount <= bufCount + 1'b1;
                2'b01:   bufCount <= bufCount - 1'b1;
                default: bufCount <= bufCount;
            endcase
        end
    end

    always_ff @(posedge HCLK) begin
        if (txValid_i) begin
            holdBuf[bufWrPtr] <= txData_i;
        end
    end

    always_ff @(posedge HCLK) begin
        if (!HRESETn) begin
            state    <= TX_IDLE;
            uartTx_o <= 1'b1;
            tickCnt  <= '0;
            bitCnt   <= '0;
        end else begin
            if (state != TX_IDLE && baudTick_i) begin
                tickCnt <= tickCnt + 1'b1;
            end
            case (state)
                TX_IDLE: begin
                    if (load) begin
                        state    <= TX_START;
                        uartTx_o <= 1'b0;              // Start bit
                        tickCnt  <= '0;
                    end
                end
                TX_START: begin
                    if (bitDone) begin
                        state    <= TX_DATA;
                        uartTx_o <= shiftReg[0];
                        bitCnt   <= '0;
                    end
                end
                TX_DATA: begin
                    if (bitDone) begin
                        if (bitCnt == 3'd7) begin
                            state    <= TX_STOP;
                            uartTx_o <= 1'b1;
                        end else begin
                            bitCnt   <= bitCnt + 1'b1;
                            uartTx_o <= shiftReg[1];   // Next bit after shift
                        end
                    end
                end
                TX_STOP: begin
                    if (bitDone) begin
                        state <= TX_IDLE;
                    end
                end
                default: state <= TX_IDLE;
            endcase
        end
    end

    // LSB first
    always_ff @(posedge HCLK) begin
        if (load) begin
            shiftReg <= holdBuf[bufRdPtr];
        end else if (state == TX_DATA && bitDone) begin
            shiftReg <= shiftReg >> 1;
        end
    end

    assign txCredit_o = load;                 // Slot freed as byte enters shifter
    assign txBusy_o   = (state != TX_IDLE) || (bufCount != '0);

endmodule

`default_nettype wire

/* uartRegs.sv */
// ============================
// UART registers and FIFOs
// ============================

`timescale 1ns/1ps
`default_nettype none

module uartRegs
    import uartPkg::*;
(
    input  wire      HCLK,
    input  wire      HRESETn,
    input  regAddrT  regAddr_i,
    input  byteT     regWData_i,
    input  wire      regWrite_i,
    input  wire      regRead_i,
    output byteT     regRData_o,
    output logic     baudTick_o,
    output logic     txValid_o,
    output byteT     txData_o,
    input  wire      txCredit_i,
    input  wire      txBusy_i,
    input  wire      rxValid_i,
    input  byteT     rxData_i,
    output logic     uartInt_o
);

    divisorT    divisor;
    divisorT    baudCnt;
    logic [1:0] ier;              // Bit 0 data ready, bit 1 THR empty
    logic       dlab;
    logic       overrun;
    creditT     creditCnt;

    // FIFO slot 0 is transmit, slot 1 is receive
    logic [1:0] fifoPush;
    logic [1:0] fifoPop;
    byteT       fifoWData [2];
    byteT       fifoRData [2];
    fifoCntT    fifoCount [2];

    logic txEmpty;
    logic txFull;
    logic rxEmpty;
    logic rxFull;
    logic dataReady;
    logic lsrRead;
    byteT lsrVal;
    byteT iirVal;

    assign txEmpty   = (fifoCount[0] == '0);
    assign txFull    = (fifoCount[0] == fifoCntT'(FIFO_DEPTH));
    assign rxEmpty   = (fifoCount[1] == '0);
    assign rxFull    = (fifoCount[1] == fifoCntT'(FIFO_DEPTH));
    assign dataReady = !rxEmpty;
    assign lsrRead   = regRead_i && (regAddr_i == ADDR_LSR);

    // Transmit side, full FIFO drops the write
    assign fifoPush[0]  = regWrite_i && (regAddr_i == ADDR_DATA) && !dlab && !txFull;
    assign fifoPop[0]   = txValid_o;
    assign fifoWData[0] = regWData_i;

    // Receive side, full FIFO drops the byte
    assign fifoPush[1]  = rxValid_i && !rxFull;
    assign fifoPop[1]   = regRead_i && (regAddr_i == ADDR_DATA) && !dlab && !rxEmpty;
    assign fifoWData[1] = rxData_i;

    for (genvar f = 0; f < 2; f++) begin : gFifo
        byteT    mem [FIFO_DEPTH];
        fifoPtrT wrPtr;
        fifoPtrT rdPtr;
        fifoCntT count;

        always_ff @(posedge HCLK) begin
            if (!HRESETn) begin
                wrPtr <= '0;
                rdPtr <= '0;
                count <= '0;
            end else begin
                if (fifoPush[f]) begin
                    wrPtr <= wrPtr + 1'b1;
                end
                if (fifoPop[f]) begin
                    rdPtr <= rdPtr + 1'b1;
                end
                case ({fifoPush[f], fifoPop[f]})
                    2'b10:   count <= count + 1'b1;
                    2'b01:   count <= count - 1'b1;
                    default: count <= count;
                endcase
            end
        end

        always_ff @(posedge HCLK) begin
            if (fifoPush[f]) begin
                mem[wrPtr] <= fifoWData[f];
            end
        end

        assign fifoRData[f] = mem[rdPtr];
        assign fifoCount[f] = count;
    end

    // Credit flow towards the transmitter
    assign txValid_o = (creditCnt != '0) && !txEmpty;
    assign txData_o  = fifoRData[0];

    always_ff @(posedge HCLK) begin
        if (!HRESETn) begin
            creditCnt <= creditT'(TX_CREDITS);
        end else begin
            case ({txValid_o, txCredit_i})
                2'b10:   creditCnt <= creditCnt - 1'b1;
                2'b01:   creditCnt <= creditCnt + 1'b1;
                default: creditCnt <= creditCnt;
            endcase
        end
    end

    always_ff @(posedge HCLK) begin
        if (!HRESETn) begin
            divisor <= '0;
            ier     <= '0;
            dlab    <= 1'b0;
        end else if (regWrite_i) begin
            case (regAddr_i)
                ADDR_DATA: begin
                    if (dlab) begin
                        divisor[7:0] <= regWData_i;
                    end
                end
                ADDR_IER: begin
                    if (dlab) begin
                        divisor[15:8] <= regWData_i;
                    end else begin
                        ier <= regWData_i[1:0];
                    end
                end
                ADDR_LCR: dlab <= regWData_i[7];
                default:  ;
            endcase
        end
    end

    always_ff @(posedge HCLK) begin
        if (!HRESETn) begin
            overrun <= 1'b0;
        end else if (rxValid_i && rxFull) begin
            overrun <= 1'b1;              // Set wins over the read clear
        end else if (lsrRead) begin
            overrun <= 1'b0;
        end
    end

    // 16x tick, stopped while divisor is zero
    always_ff @(posedge HCLK) begin
        if (!HRESETn) begin
            baudCnt    <= '0;
            baudTick_o <= 1'b0;
        end else if (divisor == '0) begin
            baudCnt    <= '0;
            baudTick_o <= 1'b0;
        end else if (baudCnt >= divisor - 1'b1) begin
            baudCnt    <= '0;
            baudTick_o <= 1'b1;
        end else begin
            baudCnt    <= baudCnt + 1'b1;
            baudTick_o <= 1'b0;
        end
    end

    assign lsrVal = {1'b0, txEmpty && (creditCnt == creditT'(TX_CREDITS)) && !txBusy_i,
                     txEmpty, 3'b000, overrun, dataReady};

    always_comb begin
        if (ier[0] && dataReady) begin
            iirVal = 8'h04;
        end else if (ier[1] && txEmpty) begin
            iirVal = 8'h02;
        end else begin
            iirVal = 8'h01;                // Nothing pending
        end
    end

    assign uartInt_o = (ier[0] && dataReady) || (ier[1] && txEmpty);

    always_comb begin
        case (regAddr_i)
            ADDR_DATA: regRData_o = dlab ? divisor[7:0] : fifoRData[1];
            ADDR_IER:  regRData_o = dlab ? divisor[15:8] : {6'b0, ier};
            ADDR_IIR:  regRData_o = iirVal;
            ADDR_LCR:  regRData_o = {dlab, 7'b0};
            ADDR_LSR:  regRData_o = lsrVal;
            default:   regRData_o = 8'h00;
        endcase
    end

endmodule

`default_nettype wire

/* ahbUartDecode.sv */
// ============================
// AHB-Lite slave front end
// ============================

`timescale 1ns/1ps
`default_nettype none

module ahbUartDecode
    import uartPkg::*;
(
    input  wire          HCLK,
    input  wire          HRESETn,
    input  wire          hSel_i,
    input  wire [1:0]    hTrans_i,
    input  wire          hWrite_i,
    input  wire [31:0]   hAddr_i,
    input  wire [31:0]   hWData_i,
    output logic [31:0]  hRData_o,
    output logic         hReady_o,
    output logic         hResp_o,
    output regAddrT      regAddr_o,
    output byteT         regWData_o,
    output logic         regWrite_o,
    output logic         regRead_o,
    input  byteT         regRData_i
);

    decodeStateT state;
    decodeStateT nextState;
    regAddrT     addrLatch;       // Write address held for the wait state
    logic        needAction;

    assign needAction = hSel_i && (hTrans_i != HTRANS_IDLE);

    always_ff @(posedge HCLK) begin
        if (!HRESETn) begin
            state <= INIT;
        end else begin
            state <= nextState;
        end
    end

    always_comb begin
        nextState = state;
        case (state)
            INIT:       nextState = READY;
            READY: begin
                if (needAction && hWrite_i) begin
                    nextState = WRITE_WAIT;
                end
            end
            WRITE_WAIT: nextState = READY;
            default:    nextState = INIT;
        endcase
    end

    // Address phase capture; read data is ready for the data phase
    always_ff @(posedge HCLK) begin
        if (state == READY) begin
            addrLatch <= hAddr_i[4:2];
            if (needAction && !hWrite_i) begin
                hRData_o <= {24'h0, regRData_i};
            end
        end
    end

    assign hReady_o   = (state == READY);
    assign hResp_o    = 1'b0;                        // Always OKAY

    assign regAddr_o  = (state == WRITE_WAIT) ? addrLatch : hAddr_i[4:2];
    assign regWData_o = hWData_i[7:0];               // Byte lane 0 only
    assign regWrite_o = (state == WRITE_WAIT);
    assign regRead_o  = (state == READY) && needAction && !hWrite_i;

endmodule

`default_nettype wire

/* uartPkg.sv */
// ============================
// UART shared definitions
// ============================

`default_nettype none

package uartPkg;

    typedef logic [2:0]  regAddrT;   // Word offset from HADDR[4:2]
    typedef logic [7:0]  byteT;
    typedef logic [15:0] divisorT;   // HCLK cycles per 16x tick

    typedef enum logic [1:0] {INIT, READY, WRITE_WAIT} decodeStateT;
    typedef enum logic [1:0] {TX_IDLE, TX_START, TX_DATA, TX_STOP} txStateT;
    typedef enum logic [1:0] {RX_IDLE, RX_START, RX_DATA, RX_STOP} rxStateT;

    // Register map, DLAB aliases divisor onto DATA and IER
    localparam regAddrT ADDR_DATA = 3'd0;
    localparam regAddrT ADDR_IER  = 3'd1;
    localparam regAddrT ADDR_IIR  = 3'd2;
    localparam regAddrT ADDR_LCR  = 3'd3;
    localparam regAddrT ADDR_LSR  = 3'd5;

    localparam int TX_CREDITS = 2;     // Transmitter holding buffer depth
    localparam int FIFO_DEPTH = 4;

    localparam logic [1:0] HTRANS_IDLE = 2'b00;

    localparam int FIFO_PTR_W = $clog2(FIFO_DEPTH);
    localparam int FIFO_CNT_W = $clog2(FIFO_DEPTH + 1);
    localparam int CREDIT_W   = $clog2(TX_CREDITS + 1);

    typedef logic [FIFO_PTR_W-1:0] fifoPtrT;
    typedef logic [FIFO_CNT_W-1:0] fifoCntT;
    typedef logic [CREDIT_W-1:0]   creditT;   // 0 to TX_CREDITS

endpackage

`default_nettype wire
